// File: Makefile
# Verilator build and run of the BPU testbench

SOURCES := $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/Vbpu_tb
	out=$$(./obj_dir/Vbpu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

obj_dir/Vbpu_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module bpu_tb -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
hw/bpu_pkg.sv
hw/ftb_table.sv
hw/ftb_sweep_counter.sv
hw/ftb_maint_fsm.sv
hw/bpu_pred_pipe.sv
hw/bpu_top.sv
tests/bpu_tb.sv

// File: hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // address layout of a fetch block
    localparam int ADDR_W = 32;
    localparam int IDX_LSB = 4;
    localparam int IDX_W = 6;
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam int TAG_W = ADDR_W - TAG_LSB;

    localparam int OFF_W = 2;
    localparam int CTR_W = 2;
    localparam int BR_TYPE_W = 2;

    // table size and fetch geometry
    localparam int FTB_ENTRIES = 1 << IDX_W;
    localparam int FETCH_BYTES = 16;
    localparam int INST_BYTES = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0] ftb_idx_t;
    typedef logic [TAG_W-1:0] ftb_tag_t;
    typedef logic [OFF_W-1:0] br_off_t;
    typedef logic [BR_TYPE_W-1:0] br_type_t;
    typedef logic [CTR_W-1:0] ctr_t;

    localparam addr_t INIT_PC = 32'h8000_0000;

    // branch type encodings
    localparam br_type_t BR_COND = 2'd0;
    localparam br_type_t BR_JUMP = 2'd1;
    localparam br_type_t BR_CALL = 2'd2;
    localparam br_type_t BR_RET = 2'd3;

    // weakly not taken is reported on a miss
    localparam ctr_t CTR_MISS = 2'd1;
    // conditional branches are taken from this value up
    localparam ctr_t CTR_TAKEN_MIN = 2'd2;

    // last entry visited by the clear sweep
    localparam ftb_idx_t FTB_LAST_IDX = ftb_idx_t'(FTB_ENTRIES - 1);

    // maintenance FSM states
    typedef enum logic [1:0] {
        MS_CLEAR,
        MS_IDLE,
        MS_WRITE,
        MS_DONE
    } maint_state_t;

endpackage

`default_nettype wire

// File: hw/bpu_pred_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_pred_pipe import bpu_pkg::*; (
    input  wire           clk,
    input  wire           rst,

    input  wire           i_squash_vld,
    input  wire addr_t    i_squash_pc,
    input  wire           i_busy,
    input  wire           i_ftq_rdy,

    // FTB lookup
    output addr_t         o_rd_pc,
    output logic          o_rd_en,
    input  wire           i_rd_hit,
    input  wire br_off_t  i_rd_off,
    input  wire addr_t    i_rd_target,
    input  wire br_type_t i_rd_type,
    input  wire ctr_t     i_rd_ctr,

    // prediction to the FTQ
    output logic          o_pred_vld,
    output addr_t         o_pred_start,
    output addr_t         o_pred_end,
    output logic          o_pred_taken,
    output addr_t         o_pred_target,
    output logic          o_pred_hit,
    output br_type_t      o_pred_type,
    output ctr_t          o_pred_ctr
);

    addr_t base_pc;

    logic s1_vld;
    addr_t s1_pc;

    logic s2_vld;
    addr_t s2_pc;
    logic s2_hit;
    br_off_t s2_off;
    addr_t s2_target;
    br_type_t s2_type;
    ctr_t s2_ctr;

    logic advance;
    logic accept;
    logic redirect;
    logic lookup;

    logic s2_taken;
    addr_t s2_fallthru;
    addr_t s2_end;
    addr_t s2_next;
    addr_t rewind_pc;

    // every stage holds while the FTQ is not ready
    assign advance = i_ftq_rdy && !i_busy;
    assign o_pred_vld = s2_vld && !i_busy;
    assign accept = o_pred_vld && i_ftq_rdy;
    assign redirect = accept && s2_hit;

    // a new lookup enters stage 1 only when nothing redirects the base
    assign lookup = advance && !i_squash_vld && !redirect;

    assign o_rd_pc = base_pc;
    assign o_rd_en = lookup;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            s2_hit <= 1'b0;
        end else if (i_squash_vld || redirect || i_busy) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else if (lookup) begin
            s1_vld <= 1'b1;
            s2_vld <= s1_vld;
            s2_hit <= s1_vld && i_rd_hit;
        end
    end

    // table data belongs to the address in stage 1
    always_ff @(posedge clk) begin
        if (lookup) begin
            s1_pc <= base_pc;
            s2_pc <= s1_pc;
            s2_off <= i_rd_off;
            s2_target <= i_rd_target;
            s2_type <= i_rd_type;
            s2_ctr <= i_rd_ctr;
        end
    end

    // block ends right after the branch word
    assign s2_fallthru = s2_pc + (addr_t'(s2_off) + addr_t'(1)) * addr_t'(INST_BYTES);

    assign s2_taken = s2_hit && ((s2_type != BR_COND) || (s2_ctr >= CTR_TAKEN_MIN));
    assign s2_end = s2_hit ? s2_fallthru : s2_pc + addr_t'(FETCH_BYTES);
    assign s2_next = s2_taken ? s2_target : s2_end;

    // oldest block the FTQ has not taken yet
    assign rewind_pc = s2_vld ? s2_pc : (s1_vld ? s1_pc : base_pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            base_pc <= INIT_PC;
        end else if (i_squash_vld) begin
            base_pc <= i_squash_pc;
        end else if (redirect) begin
            base_pc <= s2_next;
        end else if (i_busy) begin
            base_pc <= rewind_pc;
        end else if (advance) begin
            base_pc <= base_pc + addr_t'(FETCH_BYTES);
        end
    end

    assign o_pred_start = s2_pc;
    assign o_pred_end = s2_end;
    assign o_pred_taken = s2_taken;
    // on a miss the target is just the sequential next block
    assign o_pred_target = s2_hit ? s2_target : s2_end;
    assign o_pred_hit = s2_hit;
    assign o_pred_type = s2_hit ? s2_type : BR_COND;
    assign o_pred_ctr = s2_hit ? s2_ctr : CTR_MISS;

endmodule

`default_nettype wire

// File: hw/bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top import bpu_pkg::*; (
    input  wire           clk,
    input  wire           rst,

    input  wire           i_squash_vld,
    input  wire addr_t    i_squash_pc,

    // update fields stay stable until o_update_finished
    input  wire           i_update_vld,
    input  wire addr_t    i_update_pc,
    input  wire br_off_t  i_update_off,
    input  wire addr_t    i_update_target,
    input  wire br_type_t i_update_type,
    input  wire ctr_t     i_update_ctr,
    output logic          o_update_finished,

    input  wire           i_ftq_rdy,
    output logic          o_pred_vld,
    output addr_t         o_pred_start,
    output addr_t         o_pred_end,
    output logic          o_pred_taken,
    output addr_t         o_pred_target,
    output logic          o_pred_hit,
    output br_type_t      o_pred_type,
    output ctr_t          o_pred_ctr
);

    addr_t rd_pc;
    logic rd_en;
    logic rd_hit;
    br_off_t rd_off;
    addr_t rd_target;
    br_type_t rd_type;
    ctr_t rd_ctr;

    logic clr_en;
    logic clr_last;
    ftb_idx_t clr_idx;
    logic wr_en;
    logic busy;

    bpu_pred_pipe pred_pipe_inst (
        .clk           (clk),
        .rst           (rst),
        .i_squash_vld  (i_squash_vld),
        .i_squash_pc   (i_squash_pc),
        .i_busy        (busy),
        .i_ftq_rdy     (i_ftq_rdy),
        .o_rd_pc       (rd_pc),
        .o_rd_en       (rd_en),
        .i_rd_hit      (rd_hit),
        .i_rd_off      (rd_off),
        .i_rd_target   (rd_target),
        .i_rd_type     (rd_type),
        .i_rd_ctr      (rd_ctr),
        .o_pred_vld    (o_pred_vld),
        .o_pred_start  (o_pred_start),
        .o_pred_end    (o_pred_end),
        .o_pred_taken  (o_pred_taken),
        .o_pred_target (o_pred_target),
        .o_pred_hit    (o_pred_hit),
        .o_pred_type   (o_pred_type),
        .o_pred_ctr    (o_pred_ctr)
    );

    ftb_table table_inst (
        .clk         (clk),
        .rst         (rst),
        .i_rd_pc     (rd_pc),
        .i_rd_en     (rd_en),
        .o_rd_hit    (rd_hit),
        .o_rd_off    (rd_off),
        .o_rd_target (rd_target),
        .o_rd_type   (rd_type),
        .o_rd_ctr    (rd_ctr),
        .i_wr_en     (wr_en),
        .i_wr_pc     (i_update_pc),
        .i_wr_off    (i_update_off),
        .i_wr_target (i_update_target),
        .i_wr_type   (i_update_type),
        .i_wr_ctr    (i_update_ctr),
        .i_clr_en    (clr_en),
        .i_clr_idx   (clr_idx)
    );

    ftb_maint_fsm maint_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .i_update_vld (i_update_vld),
        .i_clr_last   (clr_last),
        .o_clr_en     (clr_en),
        .o_wr_en      (wr_en),
        .o_busy       (busy),
        .o_finished   (o_update_finished)
    );

    ftb_sweep_counter sweep_counter_inst (
        .clk    (clk),
        .rst    (rst),
        .i_en   (clr_en),
        .o_idx  (clr_idx),
        .o_last (clr_last)
    );

endmodule

`default_nettype wire

// File: hw/ftb_maint_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ftb_maint_fsm import bpu_pkg::*; (
    input  wire  clk,
    input  wire  rst,

    // update strobe from the backend
    input  wire  i_update_vld,
    // last entry of the clear sweep
    input  wire  i_clr_last,

    output logic o_clr_en,
    output logic o_wr_en,
    output logic o_busy,
    output logic o_finished
);

    maint_state_t state_q;
    maint_state_t state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MS_CLEAR;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_CLEAR: begin
                // one entry per cycle until the counter reaches the end
                if (i_clr_last) begin
                    state_d = MS_IDLE;
                end
            end
            MS_IDLE: begin
                if (i_update_vld) begin
                    state_d = MS_WRITE;
                end
            end
            MS_WRITE: begin
                state_d = MS_DONE;
            end
            MS_DONE: begin
                state_d = MS_IDLE;
            end
            default: begin
                state_d = MS_CLEAR;
            end
        endcase
    end

    assign o_clr_en = (state_q == MS_CLEAR);

    // the table samples the update fields here, one cycle after the strobe
    assign o_wr_en = (state_q == MS_WRITE);

    // prediction is held off in every state but idle
    assign o_busy = (state_q != MS_IDLE);

    assign o_finished = (state_q == MS_DONE);

endmodule

`default_nettype wire

// File: hw/ftb_sweep_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ftb_sweep_counter import bpu_pkg::*; (
    input  wire   clk,
    input  wire   rst,
    input  wire   i_en,
    output ftb_idx_t o_idx,
    output logic  o_last
);

    ftb_idx_t idx_q;

    // wraps back to entry zero after the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q <= '0;
        end else if (i_en) begin
            idx_q <= idx_q + ftb_idx_t'(1);
        end
    end

    assign o_idx = idx_q;

    // tells the FSM the sweep finishes this cycle
    assign o_last = (idx_q == FTB_LAST_IDX);

endmodule

`default_nettype wire

// File: hw/ftb_table.sv
`timescale 1ns/1ps
`default_nettype none

module ftb_table import bpu_pkg::*; (
    input  wire           clk,
    input  wire           rst,

    // lookup port
    input  wire addr_t    i_rd_pc,
    input  wire           i_rd_en,
    output logic          o_rd_hit,
    output br_off_t       o_rd_off,
    output addr_t         o_rd_target,
    output br_type_t      o_rd_type,
    output ctr_t          o_rd_ctr,

    // update port, one full entry per write
    input  wire           i_wr_en,
    input  wire addr_t    i_wr_pc,
    input  wire br_off_t  i_wr_off,
    input  wire addr_t    i_wr_target,
    input  wire br_type_t i_wr_type,
    input  wire ctr_t     i_wr_ctr,

    // sweep clear
    input  wire           i_clr_en,
    input  wire ftb_idx_t i_clr_idx
);

    logic [FTB_ENTRIES-1:0] valid_q;

    ftb_tag_t tag_mem [FTB_ENTRIES];
    br_off_t off_mem [FTB_ENTRIES];
    addr_t target_mem [FTB_ENTRIES];
    br_type_t type_mem [FTB_ENTRIES];
    ctr_t ctr_mem [FTB_ENTRIES];

    ftb_idx_t rd_idx_q;
    ftb_tag_t rd_tag_q;
    ftb_idx_t wr_idx;
    ftb_tag_t wr_tag;

    assign wr_idx = i_wr_pc[IDX_LSB +: IDX_W];
    assign wr_tag = i_wr_pc[TAG_LSB +: TAG_W];

    // the clear sweep drops each valid bit and a write sets one
    always_ff @(posedge clk) begin
        if (i_clr_en) begin
            valid_q[i_clr_idx] <= 1'b0;
        end
        if (i_wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[wr_idx] <= wr_tag;
            off_mem[wr_idx] <= i_wr_off;
            target_mem[wr_idx] <= i_wr_target;
            type_mem[wr_idx] <= i_wr_type;
            ctr_mem[wr_idx] <= i_wr_ctr;
        end
    end

    // lookup address is captured, data follows one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_idx_q <= '0;
        end else if (i_rd_en) begin
            rd_idx_q <= i_rd_pc[IDX_LSB +: IDX_W];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            rd_tag_q <= i_rd_pc[TAG_LSB +: TAG_W];
        end
    end

    assign o_rd_hit = valid_q[rd_idx_q] && (tag_mem[rd_idx_q] == rd_tag_q);
    assign o_rd_off = off_mem[rd_idx_q];
    assign o_rd_target = target_mem[rd_idx_q];
    assign o_rd_type = type_mem[rd_idx_q];
    assign o_rd_ctr = ctr_mem[rd_idx_q];

endmodule

`default_nettype wire

// File: tests/bpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_tb import bpu_pkg::*; ();

    localparam int OP_UPDATE = 0;
    localparam int OP_SQUASH = 1;
    localparam int OP_SQUASH_RAND = 2;
    localparam int OP_RUN = 3;
    localparam int OP_STALL = 4;

    logic clk;
    logic rst;
    logic i_squash_vld;
    addr_t i_squash_pc;
    logic i_update_vld;
    addr_t i_update_pc;
    br_off_t i_update_off;
    addr_t i_update_target;
    br_type_t i_update_type;
    ctr_t i_update_ctr;
    logic i_ftq_rdy;
    logic o_update_finished;
    logic o_pred_vld;
    addr_t o_pred_start;
    addr_t o_pred_end;
    logic o_pred_taken;
    addr_t o_pred_target;
    logic o_pred_hit;
    br_type_t o_pred_type;
    ctr_t o_pred_ctr;

    // reference copy of the FTB that finished updates fill
    logic m_valid [FTB_ENTRIES];
    ftb_tag_t m_tag [FTB_ENTRIES];
    br_off_t m_off [FTB_ENTRIES];
    addr_t m_target [FTB_ENTRIES];
    br_type_t m_type [FTB_ENTRIES];
    ctr_t m_ctr [FTB_ENTRIES];

    // start address the next accepted block must have
    addr_t exp_start;
    int errors;
    int timeouts;
    int accepts;
    bit timed_out;
    string cur_name;

    // payload seen while the FTQ held the block back
    bit have_snap;
    addr_t snap_start;
    addr_t snap_end;
    addr_t snap_target;
    logic snap_taken;
    logic snap_hit;
    br_type_t snap_type;
    ctr_t snap_ctr;

    // stimulus table with one entry per row in each queue
    string row_name [$];
    int row_op [$];
    addr_t row_pc [$];
    br_off_t row_off [$];
    addr_t row_target [$];
    br_type_t row_type [$];
    ctr_t row_ctr [$];
    int row_n [$];

    bpu_top bpu_top_inst (
        .clk               (clk),
        .rst               (rst),
        .i_squash_vld      (i_squash_vld),
        .i_squash_pc       (i_squash_pc),
        .i_update_vld      (i_update_vld),
        .i_update_pc       (i_update_pc),
        .i_update_off      (i_update_off),
        .i_update_target   (i_update_target),
        .i_update_type     (i_update_type),
        .i_update_ctr      (i_update_ctr),
        .o_update_finished (o_update_finished),
        .i_ftq_rdy         (i_ftq_rdy),
        .o_pred_vld        (o_pred_vld),
        .o_pred_start      (o_pred_start),
        .o_pred_end        (o_pred_end),
        .o_pred_taken      (o_pred_taken),
        .o_pred_target     (o_pred_target),
        .o_pred_hit        (o_pred_hit),
        .o_pred_type       (o_pred_type),
        .o_pred_ctr        (o_pred_ctr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input string name, input int op, input addr_t pc, input br_off_t off,
                           input addr_t target, input br_type_t typ, input ctr_t ctr,
                           input int n);
        row_name.push_back(name);
        row_op.push_back(op);
        row_pc.push_back(pc);
        row_off.push_back(off);
        row_target.push_back(target);
        row_type.push_back(typ);
        row_ctr.push_back(ctr);
        row_n.push_back(n);
    endtask

    task automatic build_table();
        add_row("reset_miss_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 6);
        add_row("install_jump", OP_UPDATE, 32'h8000_0080, 2'd2, 32'h8000_1000, BR_JUMP, 2'd0, 0);
        add_row("jump_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 6);
        add_row("install_cond_weak", OP_UPDATE, 32'h8000_1040, 2'd1, 32'h8000_2000, BR_COND,
                2'd1, 0);
        add_row("cond_weak_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 5);
        add_row("squash_revisit", OP_SQUASH, 32'h8000_1040, 2'd0, 32'h0, BR_COND, 2'd0, 0);
        add_row("install_cond_strong", OP_UPDATE, 32'h8000_1040, 2'd1, 32'h8000_2000, BR_COND,
                2'd3, 0);
        add_row("cond_strong_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 3);
        // closes a loop back to 0x8000_0060 for the stall run
        add_row("install_call", OP_UPDATE, 32'h8000_2020, 2'd3, 32'h8000_0060, BR_CALL, 2'd0, 0);
        add_row("squash_far", OP_SQUASH, 32'h9000_0000, 2'd0, 32'h0, BR_COND, 2'd0, 0);
        add_row("far_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 4);
        add_row("squash_loop", OP_SQUASH, 32'h8000_0060, 2'd0, 32'h0, BR_COND, 2'd0, 0);
        add_row("stall_run", OP_STALL, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 40);
        // 0x8000_0480 shares index 8 with the jump entry
        add_row("squash_alias", OP_SQUASH, 32'h8000_0470, 2'd0, 32'h0, BR_COND, 2'd0, 0);
        add_row("alias_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 4);
        add_row("squash_filler", OP_SQUASH_RAND, 32'hA000_0000, 2'd0, 32'h0, BR_COND, 2'd0, 0);
        add_row("filler_run", OP_RUN, 32'h0, 2'd0, 32'h0, BR_COND, 2'd0, 3);
    endtask

    task automatic check_val(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_name, field, exp, act);
            errors++;
        end
    endtask

    // runs at the falling edge before the rising edge that accepts
    task automatic observe_cycle();
        ftb_idx_t idx;
        logic hit;
        logic taken;
        addr_t exp_end;
        ctr_t exp_ctr;
        if (o_pred_vld && have_snap) begin
            check_val("held start", snap_start, o_pred_start);
            check_val("held end", snap_end, o_pred_end);
            check_val("held target", snap_target, o_pred_target);
            check_val("held taken", 32'(snap_taken), 32'(o_pred_taken));
            check_val("held hit", 32'(snap_hit), 32'(o_pred_hit));
            check_val("held type", 32'(snap_type), 32'(o_pred_type));
            check_val("held ctr", 32'(snap_ctr), 32'(o_pred_ctr));
        end
        have_snap = 1'b0;
        if (o_pred_vld && !i_ftq_rdy) begin
            have_snap = 1'b1;
            snap_start = o_pred_start;
            snap_end = o_pred_end;
            snap_target = o_pred_target;
            snap_taken = o_pred_taken;
            snap_hit = o_pred_hit;
            snap_type = o_pred_type;
            snap_ctr = o_pred_ctr;
        end
        if (o_pred_vld && i_ftq_rdy) begin
            idx = exp_start[IDX_LSB +: IDX_W];
            hit = m_valid[idx] && (m_tag[idx] == exp_start[TAG_LSB +: TAG_W]);
            if (hit) begin
                exp_end = exp_start + addr_t'((int'(m_off[idx]) + 1) * 4);
                taken = (m_type[idx] != BR_COND) || (m_ctr[idx] >= 2'd2);
                exp_ctr = m_ctr[idx];
                check_val("target", m_target[idx], o_pred_target);
                check_val("type", 32'(m_type[idx]), 32'(o_pred_type));
            end else begin
                exp_end = exp_start + addr_t'(FETCH_BYTES);
                taken = 1'b0;
                exp_ctr = 2'd1;
            end
            check_val("start", exp_start, o_pred_start);
            check_val("end", exp_end, o_pred_end);
            check_val("taken", 32'(taken), 32'(o_pred_taken));
            check_val("hit", 32'(hit), 32'(o_pred_hit));
            check_val("ctr", 32'(exp_ctr), 32'(o_pred_ctr));
            accepts++;
            exp_start = taken ? m_target[idx] : exp_end;
        end
    endtask

    task automatic drive_cycle(input logic rdy);
        @(posedge clk);
        i_ftq_rdy <= rdy;
        i_squash_vld <= 1'b0;
        i_update_vld <= 1'b0;
        @(negedge clk);
        observe_cycle();
    endtask

    task automatic do_squash(input addr_t pc);
        @(posedge clk);
        i_ftq_rdy <= 1'b0;
        i_squash_vld <= 1'b1;
        i_squash_pc <= pc;
        @(negedge clk);
        observe_cycle();
        exp_start = pc;
    endtask

    task automatic do_update(input addr_t pc, input br_off_t off, input addr_t target,
                             input br_type_t typ, input ctr_t ctr);
        int waited;
        ftb_idx_t idx;
        @(posedge clk);
        i_ftq_rdy <= 1'b0;
        i_update_vld <= 1'b1;
        i_update_pc <= pc;
        i_update_off <= off;
        i_update_target <= target;
        i_update_type <= typ;
        i_update_ctr <= ctr;
        @(negedge clk);
        observe_cycle();
        waited = 0;
        do begin
            drive_cycle(1'b0);
            waited++;
        end while (!o_update_finished && waited < 10);
        if (!o_update_finished) begin
            $display("timeout: update of %h never raised o_update_finished", pc);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            check_val("finish delay", 32'd2, waited);
            idx = pc[IDX_LSB +: IDX_W];
            m_valid[idx] = 1'b1;
            m_tag[idx] = pc[TAG_LSB +: TAG_W];
            m_off[idx] = off;
            m_target[idx] = target;
            m_type[idx] = typ;
            m_ctr[idx] = ctr;
        end
    endtask

    task automatic run_blocks(input int n, input bit stall);
        int start_acc;
        int waited;
        int limit;
        start_acc = accepts;
        waited = 0;
        limit = n * 12 + 40;
        while ((accepts - start_acc) < n && waited < limit) begin
            drive_cycle(stall ? (($urandom % 3) != 0) : 1'b1);
            waited++;
        end
        if ((accepts - start_acc) < n) begin
            $display("timeout: %s accepted only %0d of %0d blocks", cur_name,
                     accepts - start_acc, n);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h8692));
        rst = 1'b1;
        i_squash_vld = 1'b0;
        i_squash_pc = '0;
        i_update_vld = 1'b0;
        i_update_pc = '0;
        i_update_off = '0;
        i_update_target = '0;
        i_update_type = BR_COND;
        i_update_ctr = '0;
        i_ftq_rdy = 1'b0;
        errors = 0;
        timeouts = 0;
        accepts = 0;
        timed_out = 1'b0;
        have_snap = 1'b0;
        exp_start = INIT_PC;
        for (int i = 0; i < FTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        build_table();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        i_ftq_rdy <= 1'b1;

        // the sweep keeps prediction off for one cycle per entry
        cur_name = "reset_clear";
        for (int c = 0; c < FTB_ENTRIES; c++) begin
            @(negedge clk);
            check_val("pred_vld", 32'd0, 32'(o_pred_vld));
            check_val("update_finished", 32'd0, 32'(o_update_finished));
        end

        for (int r = 0; r < row_name.size() && !timed_out; r++) begin
            cur_name = row_name[r];
            case (row_op[r])
                OP_UPDATE: do_update(row_pc[r], row_off[r], row_target[r], row_type[r],
                                     row_ctr[r]);
                OP_SQUASH: do_squash(row_pc[r]);
                OP_SQUASH_RAND: do_squash(row_pc[r] | ($urandom & 32'h000F_FFF0));
                OP_RUN: run_blocks(row_n[r], 1'b0);
                OP_STALL: run_blocks(row_n[r], 1'b1);
                default: begin
                    $display("unknown operation in row %s", row_name[r]);
                    errors++;
                end
            endcase
        end

        $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
